//--- src/rv_exec_defs.svh
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

`define RV_XLEN      32              // Data and PC width
`define RV_NUM_REGS  32              // Architectural registers, x0 included

`define RV_OPC_LUI    7'b0110111     // U-type
`define RV_OPC_AUIPC  7'b0010111     // U-type
`define RV_OPC_JAL    7'b1101111     // J-type
`define RV_OPC_JALR   7'b1100111     // I-type
`define RV_OPC_BRANCH 7'b1100011     // B-type
`define RV_OPC_OP_IMM 7'b0010011     // I-type arithmetic
`define RV_OPC_OP     7'b0110011     // R-type arithmetic

`define RV_F3_ADD     3'b000         // ADD/SUB, ADDI, JALR
`define RV_F3_SLL     3'b001         // SLL, SLLI
`define RV_F3_SR      3'b101         // SRL/SRA, SRLI/SRAI

`define RV_F7_BASE    7'b0000000     // Plain encoding
`define RV_F7_ALT     7'b0100000     // SUB, SRA, SRAI

`endif

//--- src/rv_exec_pkg.sv
package rv_exec_pkg;

  // One data, PC or immediate word
  typedef logic [31:0] word_t;

  // Register index, x0 to x31
  typedef logic [4:0] reg_addr_t;

  // Operand set and result rule selected by the decoder
  typedef enum logic [2:0] {
    OP_REG     = 3'd0,  // rs1 op rs2
    OP_IMM     = 3'd1,  // rs1 op imm
    OP_LUI     = 3'd2,  // imm
    OP_AUIPC   = 3'd3,  // pc + imm
    OP_JAL     = 3'd4,  // Link pc + 4, target pc + imm
    OP_JALR    = 3'd5,  // Link pc + 4, target rs1 + imm
    OP_BRANCH  = 3'd6,  // Compare only, no write
    OP_ILLEGAL = 3'd7   // Anything not supported
  } op_class_t;

  // The ALU keys its
  // result mux and its
  // writeback rule on
  // this one field, so
  // the decoder is the
  // only place that
  // looks at opcodes

endpackage

//--- src/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_decoder
  import rv_exec_pkg::*;
(
  input  word_t     i_instr,
  output reg_addr_t o_rs1,
  output reg_addr_t o_rs2,
  output reg_addr_t o_rd,
  output logic [2:0] o_funct3,
  output logic      o_funct7_alt,
  output word_t     o_imm,
  output op_class_t o_class,
  output logic      o_wr_en
);

  logic [6:0] opcode;                 // Major opcode
  logic [6:0] funct7;                 // R-type funct7 / shift imm top
  logic       f7_base;                // funct7 is all zero
  logic       f7_alt;                 // funct7 is 0100000
  word_t      imm_i;                  // I-type immediate
  word_t      imm_u;                  // U-type immediate
  word_t      imm_j;                  // J-type immediate
  word_t      imm_b;                  // B-type immediate

  assign opcode   = i_instr[6:0];
  assign o_rd     = i_instr[11:7];
  assign o_funct3 = i_instr[14:12];
  assign o_rs1    = i_instr[19:15];
  assign o_rs2    = i_instr[24:20];
  assign funct7   = i_instr[31:25];
  assign f7_base  = (funct7 == `RV_F7_BASE);
  assign f7_alt   = (funct7 == `RV_F7_ALT);

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
  assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};

  always_comb
  begin
    o_class = OP_ILLEGAL;             // Default: unsupported, no write
    o_wr_en = 1'b0;
    o_imm   = imm_i;
    case (opcode)
      `RV_OPC_LUI:
      begin
        o_class = OP_LUI;
        o_wr_en = 1'b1;
        o_imm   = imm_u;
      end
      `RV_OPC_AUIPC:
      begin
        o_class = OP_AUIPC;
        o_wr_en = 1'b1;
        o_imm   = imm_u;
      end
      `RV_OPC_JAL:
      begin
        o_class = OP_JAL;
        o_wr_en = 1'b1;
        o_imm   = imm_j;
      end
      `RV_OPC_JALR:
      begin
        if (o_funct3 == `RV_F3_ADD)   // Only funct3 000 is defined
        begin
          o_class = OP_JALR;
          o_wr_en = 1'b1;
        end
      end
      `RV_OPC_BRANCH:
      begin
        o_imm = imm_b;
        if (o_funct3[2:1] != 2'b01)   // funct3 2 and 3 are reserved
        begin
          o_class = OP_BRANCH;
        end
      end
      `RV_OPC_OP_IMM:
      begin
        // Shifts carry a funct7 in imm[11:5]
        if ((o_funct3 == `RV_F3_SLL && f7_base) ||
            (o_funct3 == `RV_F3_SR && (f7_base || f7_alt)) ||
            (o_funct3 != `RV_F3_SLL && o_funct3 != `RV_F3_SR))
        begin
          o_class = OP_IMM;
          o_wr_en = 1'b1;
        end
      end
      `RV_OPC_OP:
      begin
        if (f7_base || (f7_alt && (o_funct3 == `RV_F3_ADD || o_funct3 == `RV_F3_SR)))
        begin
          o_class = OP_REG;
          o_wr_en = 1'b1;
        end
      end
      default:
      begin
        o_class = OP_ILLEGAL;
      end
    endcase
  end

  // SUB/SRA select, never set for ADDI with imm[10] high
  assign o_funct7_alt = i_instr[30] &&
                        ((o_class == OP_REG) || (o_class == OP_IMM && o_funct3 == `RV_F3_SR));

  always_comb
  begin
    a_no_wr_branch_illegal: assert final (!(o_wr_en && (o_class inside {OP_ILLEGAL, OP_BRANCH})))
      else $error("rv_decoder: write enabled for branch or illegal instruction");
  end

endmodule

//--- src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
  import rv_exec_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  input  reg_addr_t i_wr_addr,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data,
  input  logic      i_wr_en,
  input  word_t     i_wr_data
);

  word_t regs [1:31];                 // x0 has no storage

  // One flop bank per register, x0 never matches
  for (genvar g = 1; g < 32; g++)
  begin : g_reg
    always_ff @(posedge i_clk)
    begin
      if (i_rst)
      begin
        regs[g] <= '0;                // Architectural state clears
      end
      else if (i_wr_en && (i_wr_addr == reg_addr_t'(g)))
      begin
        regs[g] <= i_wr_data;
      end
    end
  end

  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];  // x0 reads zero
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

  // x0 reads zero on both ports
  a_x0_rs1_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_rs1_addr == '0) |-> (o_rs1_data == '0));
  a_x0_rs2_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_rs2_addr == '0) |-> (o_rs2_data == '0));

endmodule

//--- src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
  import rv_exec_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_valid,
  input  op_class_t  i_class,
  input  logic [2:0] i_funct3,
  input  logic       i_funct7_alt,
  input  word_t      i_rs1_data,
  input  word_t      i_rs2_data,
  input  word_t      i_imm,
  input  word_t      i_pc,
  input  reg_addr_t  i_rd,
  input  logic       i_wr_en,
  output logic       o_wb_en,
  output reg_addr_t  o_wb_addr,
  output word_t      o_wb_data,
  output logic       o_valid,
  output word_t      o_result,
  output reg_addr_t  o_rd,
  output logic       o_branch_taken,
  output word_t      o_target,
  output logic       o_illegal
);

  word_t      op_b;                   // rs2 or immediate
  logic [4:0] shamt;                  // Low 5 bits only
  word_t      arith;                  // funct3 operation result
  logic       cond;                   // Branch comparison outcome
  word_t      result;                 // Value for rd
  word_t      target;                 // Redirect address
  word_t      jalr_sum;               // rs1 + imm before alignment
  logic       taken;                  // Redirect this instruction
  logic       illegal;

  assign op_b     = (i_class == OP_REG) ? i_rs2_data : i_imm;
  assign shamt    = op_b[4:0];
  assign jalr_sum = i_rs1_data + i_imm;

  always_comb
  begin
    case (i_funct3)
      3'd0:    arith = i_funct7_alt ? (i_rs1_data - op_b) : (i_rs1_data + op_b);  // ADD/SUB
      3'd1:    arith = i_rs1_data << shamt;                                       // SLL
      3'd2:    arith = {31'b0, $signed(i_rs1_data) < $signed(op_b)};             // SLT
      3'd3:    arith = {31'b0, i_rs1_data < op_b};                               // SLTU
      3'd4:    arith = i_rs1_data ^ op_b;                                         // XOR
      3'd5:    arith = i_funct7_alt ? word_t'($signed(i_rs1_data) >>> shamt)     // SRA
                                    : (i_rs1_data >> shamt);                     // SRL
      3'd6:    arith = i_rs1_data | op_b;                                         // OR
      default: arith = i_rs1_data & op_b;                                         // AND
    endcase
  end

  // Branch compare always on rs1/rs2
  always_comb
  begin
    case (i_funct3)
      3'd0:    cond = (i_rs1_data == i_rs2_data);                   // BEQ
      3'd1:    cond = (i_rs1_data != i_rs2_data);                   // BNE
      3'd4:    cond = ($signed(i_rs1_data) < $signed(i_rs2_data));  // BLT
      3'd5:    cond = ($signed(i_rs1_data) >= $signed(i_rs2_data)); // BGE
      3'd6:    cond = (i_rs1_data < i_rs2_data);                    // BLTU
      3'd7:    cond = (i_rs1_data >= i_rs2_data);                   // BGEU
      default: cond = 1'b0;           // Decoder flags these illegal
    endcase
  end

  always_comb
  begin
    result  = '0;
    taken   = 1'b0;
    illegal = 1'b0;
    case (i_class)
      OP_REG, OP_IMM: result = arith;
      OP_LUI:         result = i_imm;
      OP_AUIPC:       result = i_pc + i_imm;
      OP_JAL, OP_JALR:
      begin
        result = i_pc + 32'd4;        // Link address
        taken  = 1'b1;
      end
      OP_BRANCH:      taken = cond;   // Result stays zero
      default:        illegal = 1'b1;
    endcase
  end

  assign target = (i_class == OP_JALR) ? {jalr_sum[31:1], 1'b0} : (i_pc + i_imm);

  // Write lands at the same edge that registers the outputs
  assign o_wb_en   = i_valid && i_wr_en && (i_rd != '0);
  assign o_wb_addr = i_rd;
  assign o_wb_data = result;

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_valid        <= 1'b0;
      o_branch_taken <= 1'b0;
      o_illegal      <= 1'b0;
    end
    else
    begin
      o_valid        <= i_valid;
      o_branch_taken <= i_valid && taken;
      o_illegal      <= i_valid && illegal;
    end
  end

  always_ff @(posedge i_clk)
  begin
    o_result <= result;               // Payload, no reset
    o_rd     <= i_rd;
    o_target <= target;
  end

  a_taken_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_branch_taken |-> o_valid);
  a_target_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    o_branch_taken |-> (o_target[0] == 1'b0));

endmodule

//--- src/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top
  import rv_exec_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_valid,
  input  word_t     i_instr,
  input  word_t     i_pc,
  output logic      o_valid,
  output word_t     o_result,
  output reg_addr_t o_rd,
  output logic      o_branch_taken,
  output word_t     o_target,
  output logic      o_illegal
);

  reg_addr_t  rs1;                    // Read port addresses
  reg_addr_t  rs2;
  reg_addr_t  rd;                     // Destination from decode
  logic       wr_en;                  // Instruction writes rd
  op_class_t  op_class;
  logic [2:0] funct3;
  logic       funct7_alt;             // SUB/SRA select
  word_t      imm;
  word_t      rs1_data;               // Operands from register file
  word_t      rs2_data;
  logic       wb_en;                  // Writeback from ALU
  reg_addr_t  wb_addr;
  word_t      wb_data;

  rv_decoder u_decoder (
    .i_instr      (i_instr),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_rd         (rd),
    .o_funct3     (funct3),
    .o_funct7_alt (funct7_alt),
    .o_imm        (imm),
    .o_class      (op_class),
    .o_wr_en      (wr_en)
  );

  rv_regfile u_regfile (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_rs1_addr (rs1), .i_rs2_addr (rs2), .i_wr_addr (wb_addr),
    .o_rs1_data (rs1_data), .o_rs2_data (rs2_data),
    .i_wr_en (wb_en), .i_wr_data (wb_data)
  );

  rv_alu u_alu (
    .i_clk (i_clk), .i_rst (i_rst), .i_valid (i_valid),
    .i_class (op_class), .i_funct3 (funct3), .i_funct7_alt (funct7_alt),
    .i_rs1_data (rs1_data), .i_rs2_data (rs2_data), .i_imm (imm), .i_pc (i_pc),
    .i_rd (rd), .i_wr_en (wr_en),
    .o_wb_en (wb_en), .o_wb_addr (wb_addr), .o_wb_data (wb_data),
    .o_valid (o_valid), .o_result (o_result), .o_rd (o_rd),
    .o_branch_taken (o_branch_taken), .o_target (o_target), .o_illegal (o_illegal)
  );

endmodule

//--- verification/rv_exec_tb.sv
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_exec_tb
  import rv_exec_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int SEED       = 87018;
  localparam int N_RAND     = 100;                        // Random OP-IMM/OP pairs
  localparam int MAX_INSTR  = 2 * N_RAND + 180;           // Directed part included
  localparam int TIMEOUT_NS = (2 * MAX_INSTR + 30) * CLK_PERIOD;  // Worst case one gap each

  logic      i_clk;
  logic      i_rst;
  logic      i_valid;
  word_t     i_instr;
  word_t     i_pc;
  logic      o_valid;
  word_t     o_result;
  reg_addr_t o_rd;
  logic      o_branch_taken;
  word_t     o_target;
  logic      o_illegal;

  word_t shadow [0:31];                                   // Architectural register model
  word_t pc;
  word_t exp_result;                                      // Expectation of last issue
  word_t exp_target;
  logic  exp_taken;
  logic  exp_illegal;
  logic  exp_tgt_chk;                                     // Target defined for this class
  reg_addr_t exp_rd;                                      // Destination field
  logic  exp_wr;                                          // Instruction has a destination
  int    exp_beh;
  word_t chk_result;                                      // Same, one edge later
  word_t chk_target;
  logic  chk_taken;
  logic  chk_illegal;
  logic  chk_tgt_chk;
  reg_addr_t chk_rd;
  logic  chk_wr;
  int    chk_beh;
  logic  valid_q;                                         // i_valid seen at last edge

  rv_exec_top rv_exec_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_valid (i_valid), .i_instr (i_instr), .i_pc (i_pc),
    .o_valid (o_valid), .o_result (o_result), .o_rd (o_rd),
    .o_branch_taken (o_branch_taken), .o_target (o_target), .o_illegal (o_illegal)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, rs1, logic [2:0] f3,
                                  reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
  endfunction

  // RV32I integer op on two operands
  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    logic signed [31:0] sa;
    sa = $signed(a) >>> b[4:0];                           // Arithmetic shift
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'(sa) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;                             // BGEU
    endcase
  endfunction

  function automatic string behavior_name(int beh);
    case (beh)
      1:       return "valid_timing";
      2:       return "lui_auipc_op_imm";
      3:       return "op_reg";
      4:       return "branch";
      5:       return "jump";
      6:       return "x0_illegal";
      7:       return "readback";
      default: return "unknown";
    endcase
  endfunction

  // Golden model, updates the expectation and the shadow registers
  task automatic predict(word_t instr, word_t pc_v);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    reg_addr_t  rd;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_j;
    word_t      imm_b;
    word_t      res;
    logic       wr;
    opc   = instr[6:0];
    f3    = instr[14:12];
    f7    = instr[31:25];
    rd    = instr[11:7];
    a     = shadow[instr[19:15]];
    b     = shadow[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    res         = '0;
    wr          = 1'b0;
    exp_taken   = 1'b0;
    exp_illegal = 1'b0;
    exp_tgt_chk = 1'b0;
    exp_target  = '0;
    case (opc)
      `RV_OPC_LUI:
      begin
        res = {instr[31:12], 12'b0};
        wr  = 1'b1;
      end
      `RV_OPC_AUIPC:
      begin
        res = pc_v + {instr[31:12], 12'b0};
        wr  = 1'b1;
      end
      `RV_OPC_JAL, `RV_OPC_JALR:
      begin
        if (opc == `RV_OPC_JALR && f3 != 3'd0)
        begin
          exp_illegal = 1'b1;
        end
        else
        begin
          res         = pc_v + 32'd4;                     // Link
          exp_target  = (opc == `RV_OPC_JAL) ? pc_v + imm_j : (a + imm_i) & ~32'd1;
          exp_taken   = 1'b1;
          exp_tgt_chk = 1'b1;
          wr          = 1'b1;
        end
      end
      `RV_OPC_BRANCH:
      begin
        if (f3 == 3'd2 || f3 == 3'd3)
        begin
          exp_illegal = 1'b1;
        end
        else
        begin
          exp_taken   = branch_ref(f3, a, b);
          exp_target  = pc_v + imm_b;
          exp_tgt_chk = 1'b1;
        end
      end
      `RV_OPC_OP_IMM:
      begin
        if ((f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20))
          exp_illegal = 1'b1;
        else
        begin
          res = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
          wr  = 1'b1;
        end
      end
      `RV_OPC_OP:
      begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
        begin
          res = alu_ref(f3, f7 == 7'h20, a, b);
          wr  = 1'b1;
        end
        else
          exp_illegal = 1'b1;
      end
      default: exp_illegal = 1'b1;
    endcase
    exp_result = res;
    exp_rd     = rd;
    exp_wr     = wr;
    if (wr && rd != 5'd0) shadow[rd] = res;               // x0 stays zero
  endtask

  // One instruction, optionally followed by an idle cycle
  task automatic issue(word_t instr, int beh, bit gap);
    @(posedge i_clk);
    #1;
    i_valid = 1'b1;
    i_instr = instr;
    i_pc    = pc;
    exp_beh = beh;
    predict(instr, pc);
    pc = pc + 32'd4;
    if (gap)
    begin
      @(posedge i_clk);
      #1;
      i_valid = 1'b0;
    end
  endtask

  // add x0, xk, x0 shows xk on o_result
  task automatic readback_all();
    for (int k = 0; k < 32; k++)
      issue(enc_r(`RV_F7_BASE, 5'd0, reg_addr_t'(k), `RV_F3_ADD, 5'd0), 7, 1'b0);
  endtask

  task automatic report_mismatch(string what, int beh, word_t exp_v, word_t act_v);
    $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h",
             behavior_name(beh), what, exp_v, act_v);
    $display("Testbench failed");
    $fatal(1);
  endtask

  always @(posedge i_clk)
  begin
    valid_q <= i_rst ? 1'b0 : i_valid;
    if (i_valid)
    begin
      chk_result  <= exp_result;                          // Due on the outputs next cycle
      chk_target  <= exp_target;
      chk_taken   <= exp_taken;
      chk_illegal <= exp_illegal;
      chk_tgt_chk <= exp_tgt_chk;
      chk_rd      <= exp_rd;
      chk_wr      <= exp_wr;
      chk_beh     <= exp_beh;
    end
  end

  a_valid_follows: assert property (@(posedge i_clk) disable iff (i_rst) o_valid == valid_q)
    else report_mismatch("o_valid", 1, $sampled(valid_q), $sampled(o_valid));
  a_flags_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    !o_valid |-> (!o_branch_taken && !o_illegal))
    else report_mismatch("idle flags", 1, 0, {$sampled(o_branch_taken), $sampled(o_illegal)});
  a_result: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid |-> (o_result == chk_result))
    else report_mismatch("o_result", $sampled(chk_beh), $sampled(chk_result), $sampled(o_result));
  a_rd: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_valid && chk_wr) |-> (o_rd == chk_rd))
    else report_mismatch("o_rd", $sampled(chk_beh), $sampled(chk_rd), $sampled(o_rd));
  a_taken: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid |-> (o_branch_taken == chk_taken))
    else report_mismatch("o_branch_taken", $sampled(chk_beh), $sampled(chk_taken),
                         $sampled(o_branch_taken));
  a_illegal: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid |-> (o_illegal == chk_illegal))
    else report_mismatch("o_illegal", $sampled(chk_beh), $sampled(chk_illegal),
                         $sampled(o_illegal));
  a_target: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_valid && chk_tgt_chk) |-> (o_target == chk_target))
    else report_mismatch("o_target", $sampled(chk_beh), $sampled(chk_target), $sampled(o_target));

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the DUT did not complete all instructions in time");
    $display("Testbench failed");
    $fatal(1);
  end

  initial
  begin
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    void'($urandom(SEED));
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_instr = '0;
    i_pc    = '0;
    pc      = 32'h0000_1000;
    for (int k = 0; k < 32; k++) shadow[k] = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    repeat (3) @(posedge i_clk);                          // Idle, flags must stay low
    for (int k = 1; k < 32; k++)
    begin
      issue(enc_u(20'($urandom), reg_addr_t'(k), `RV_OPC_LUI), 2, 1'b0);
      issue(enc_i(12'($urandom), reg_addr_t'(k), 3'd0, reg_addr_t'(k), `RV_OPC_OP_IMM), 2,
            1'($urandom));
    end
    issue(enc_u(20'($urandom), 5'd9, `RV_OPC_AUIPC), 2, 1'b0);
    issue(enc_u(20'h80000, 5'd1, `RV_OPC_LUI), 2, 1'b0);  // x1 = most negative
    issue(enc_i(12'hfff, 5'd1, 3'd2, 5'd2, `RV_OPC_OP_IMM), 2, 1'b0);  // SLTI vs -1
    issue(enc_i(12'hfff, 5'd1, 3'd3, 5'd2, `RV_OPC_OP_IMM), 2, 1'b0);  // SLTIU vs max
    issue(enc_i(12'h800, 5'd1, 3'd2, 5'd2, `RV_OPC_OP_IMM), 2, 1'b0);
    issue(enc_u(20'h7ffff, 5'd3, `RV_OPC_LUI), 2, 1'b0);
    issue(enc_i(12'h7ff, 5'd3, 3'd0, 5'd3, `RV_OPC_OP_IMM), 2, 1'b0);  // x3 large positive
    issue(enc_i(12'h800, 5'd3, 3'd2, 5'd2, `RV_OPC_OP_IMM), 2, 1'b0);
    issue(enc_i(12'h7ff, 5'd3, 3'd3, 5'd2, `RV_OPC_OP_IMM), 2, 1'b0);
    issue(enc_i({7'h20, 5'd31}, 5'd1, 3'd5, 5'd4, `RV_OPC_OP_IMM), 2, 1'b0);  // SRAI negative
    issue(enc_i({7'h20, 5'd4}, 5'd1, 3'd5, 5'd4, `RV_OPC_OP_IMM), 2, 1'b0);
    issue(enc_i({7'h00, 5'd4}, 5'd1, 3'd5, 5'd4, `RV_OPC_OP_IMM), 2, 1'b0);
    for (int f = 0; f < 8; f++)
    begin
      if (f != 2 && f != 3)
      begin
        issue(enc_b({12'($urandom), 1'b0}, 5'd3, 5'd3, 3'(f)), 4, 1'($urandom));  // Equal
        issue(enc_b({12'($urandom), 1'b0}, 5'd3, 5'd1, 3'(f)), 4, 1'($urandom));  // Neg vs pos
      end
    end
    readback_all();
    issue(enc_j({20'($urandom), 1'b0}, 5'd5), 5, 1'b0);
    issue(enc_i(12'($urandom) | 12'd1, 5'd4, 3'd0, 5'd6, `RV_OPC_JALR), 5, 1'b1);  // Odd sum
    issue(enc_i(12'($urandom), 5'd7, 3'd0, 5'd8, `RV_OPC_JALR), 5, 1'b0);
    issue(enc_r(`RV_F7_BASE, 5'd3, 5'd1, 3'd0, 5'd10), 3, 1'b0);  // Dependent chain
    issue(enc_r(`RV_F7_ALT, 5'd3, 5'd10, 3'd0, 5'd11), 3, 1'b0);
    issue(enc_r(`RV_F7_ALT, 5'd3, 5'd11, 3'd5, 5'd12), 3, 1'b0);
    issue(enc_r(`RV_F7_BASE, 5'd10, 5'd12, 3'd2, 5'd13), 3, 1'b0);
    issue(enc_r(`RV_F7_BASE, 5'd12, 5'd13, 3'd3, 5'd13), 3, 1'b0);
    for (int n = 0; n < N_RAND; n++)
    begin
      f3  = 3'($urandom);
      alt = 1'($urandom);
      imm = 12'($urandom);
      if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
      if (f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
      issue(enc_i(imm, reg_addr_t'($urandom), f3, reg_addr_t'($urandom), `RV_OPC_OP_IMM), 2,
            1'($urandom));
      alt = alt && (f3 == 3'd0 || f3 == 3'd5);             // SUB and SRA only
      issue(enc_r(alt ? `RV_F7_ALT : `RV_F7_BASE, reg_addr_t'($urandom), reg_addr_t'($urandom),
                  f3, reg_addr_t'($urandom)), 3, 1'($urandom));
    end
    issue(enc_i(12'($urandom), 5'd1, 3'd2, 5'd7, 7'b0000011), 6, 1'b0);  // Load opcode
    issue(enc_b(13'h010, 5'd3, 5'd1, 3'd2), 6, 1'b0);
    issue(enc_b(13'h020, 5'd3, 5'd1, 3'd3), 6, 1'b0);
    issue(enc_r(7'h01, 5'd3, 5'd1, 3'd0, 5'd8), 6, 1'b0);  // MUL space
    issue(enc_r(`RV_F7_ALT, 5'd3, 5'd1, 3'd4, 5'd8), 6, 1'b0);
    issue(enc_i(12'h004, 5'd1, 3'd1, 5'd9, `RV_OPC_JALR), 6, 1'b0);
    issue(enc_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd9, `RV_OPC_OP_IMM), 6, 1'b1);
    issue(enc_i(12'h123, 5'd1, 3'd0, 5'd0, `RV_OPC_OP_IMM), 6, 1'b0);  // Write to x0
    issue(enc_u(20'habcde, 5'd0, `RV_OPC_LUI), 6, 1'b0);
    issue(enc_r(`RV_F7_BASE, 5'd0, 5'd0, 3'd0, 5'd14), 6, 1'b0);
    readback_all();
    @(posedge i_clk);
    #1;
    i_valid = 1'b0;
    repeat (3) @(posedge i_clk);                          // Drain the last checks
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+src
src/rv_exec_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_exec_top.sv
verification/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - src
    files:
      - src/rv_exec_pkg.sv
      - src/rv_decoder.sv
      - src/rv_regfile.sv
      - src/rv_alu.sv
      - src/rv_exec_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/rv_exec_tb.sv
